/* hw/epath_pkg.sv */
// e-path buffer shared definitions
// word and frame layout, FIFO sizes, register map, FSM states

package epath_pkg;

  // --------------------
  // word layout
  // --------------------
  localparam int WORD_W = 18;
  localparam int DATA_W = 16;
  localparam int TYPE_W = WORD_W - DATA_W;

  // message and frame
  localparam int ID_W        = 11;
  localparam int PAYLOAD_W   = 64;
  localparam int FRAME_WORDS = 6;
  // start and end words carry no payload
  localparam int PAY_WORDS   = FRAME_WORDS - 2;

  // --------------------
  // FIFO sizing
  // --------------------
  localparam int FIFO_AW    = 4;
  localparam int FIFO_DEPTH = 1 << FIFO_AW;
  // full frame still fits below full at this level
  localparam logic [FIFO_AW-1:0] AFULL_RESET = 4'd10;

  // type field in the top two bits of every word
  typedef enum logic [TYPE_W-1:0] {
    WT_IDLE = 2'b00,
    WT_SOP  = 2'b01,
    WT_DATA = 2'b10,
    WT_EOP  = 2'b11
  } word_type_e;

  // register map
  localparam int REG_AW = 3;
  typedef enum logic [REG_AW-1:0] {
    REG_CTRL   = 3'd0,
    REG_AFULL  = 3'd1,
    REG_FRAMES = 3'd2,
    REG_ERRORS = 3'd3,
    REG_LEVEL  = 3'd4
  } reg_addr_e;

  // FSM states
  typedef enum logic [2:0] {WR_IDLE, WR_HEADER, WR_PAYLOAD, WR_TRAILER, WR_ACK_WAIT} wr_state_e;
  typedef enum logic [2:0] {RD_HUNT, RD_COLLECT, RD_CHECK, RD_OFFER, RD_RELEASE} rd_state_e;

endpackage

/* hw/epath_fifo.sv */
// single-clock 18-bit word FIFO
// full, empty, threshold almost-full and fill level

`timescale 1ns/10ps

module epath_fifo (
  input  logic                          c_clk,
  input  logic                          c_rst,
  input  logic                          wr_en,
  input  logic [epath_pkg::WORD_W-1:0]  wr_word,
  input  logic                          rd_en,
  input  logic [epath_pkg::FIFO_AW-1:0] afull_thresh,
  output logic [epath_pkg::WORD_W-1:0]  rd_word,
  output logic                          empty,
  output logic                          almost_full,
  output logic [epath_pkg::FIFO_AW-1:0] level
);
  import epath_pkg::*;

  // storage
  logic [WORD_W-1:0]  mem [FIFO_DEPTH];

  // pointers
  logic [FIFO_AW-1:0] w_ptr;
  logic [FIFO_AW-1:0] r_ptr;

  // accepted operations
  logic               full;
  logic               wr_ok;
  logic               rd_ok;

  // --------------------
  // status flags
  // --------------------
  // level from pointer difference, wraps mod depth
  assign level = w_ptr - r_ptr;

  // one slot always kept free
  assign full  = (level == FIFO_AW'(FIFO_DEPTH - 1));
  assign empty = (level == '0);

  // threshold compare, usable as a space check
  assign almost_full = (level >= afull_thresh);

  // pointer advance only on accepted ops
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // --------------------
  // memory write
  // --------------------
  always_ff @(posedge c_clk)
  begin
    if (wr_ok)
      mem[w_ptr] <= wr_word;
  end

  // --------------------
  // pointers
  // --------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      w_ptr <= '0;
      r_ptr <= '0;
    end
    else
    begin
      if (wr_ok)
        w_ptr <= w_ptr + 1'b1;
      if (rd_ok)
        r_ptr <= r_ptr + 1'b1;
    end
  end

  // registered read port
  // word valid one cycle after rd_en, zero otherwise
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
      rd_word <= '0;
    else if (rd_ok)
      rd_word <= mem[r_ptr];
    else
      rd_word <= '0;
  end

endmodule

/* hw/epath_frame_writer.sv */
// frame writer for the e-path buffer
// four-phase message intake, six-word frame out with checksum

`timescale 1ns/10ps

module epath_frame_writer (
  input  logic                            c_clk,
  input  logic                            c_rst,
  input  logic                            wr_enable,
  input  logic                            msg_req,
  input  logic [epath_pkg::ID_W-1:0]      msg_id,
  input  logic [epath_pkg::PAYLOAD_W-1:0] msg_data,
  input  logic                            almost_full,
  output logic                            msg_ack,
  output logic                            wr_en,
  output logic [epath_pkg::WORD_W-1:0]    wr_word
);
  import epath_pkg::*;

  wr_state_e                      state;
  logic [$clog2(PAY_WORDS)-1:0]   word_cnt;

  // message copy, payload shifts out msw first
  logic [ID_W-1:0]                id_q;
  logic [PAYLOAD_W-1:0]           pay_q;
  logic [DATA_W-1:0]              csum;

  logic                           start;

  // space check once per frame, full never looked at
  assign start = msg_req && wr_enable && !almost_full;

  // --------------------
  // control FSM
  // --------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      state    <= WR_IDLE;
      word_cnt <= '0;
    end
    else
    begin
      case (state)
        WR_IDLE:
          if (start)
            state <= WR_HEADER;
        WR_HEADER:
        begin
          word_cnt <= '0;
          state    <= WR_PAYLOAD;
        end
        WR_PAYLOAD:
        begin
          word_cnt <= word_cnt + 1'b1;
          if (word_cnt == PAY_WORDS - 1)
            state <= WR_TRAILER;
        end
        WR_TRAILER:
          state <= WR_ACK_WAIT;
        // hold ack until source drops req
        WR_ACK_WAIT:
          if (!msg_req)
            state <= WR_IDLE;
        default:
          state <= WR_IDLE;
      endcase
    end
  end

  // --------------------
  // message latch and checksum
  // --------------------
  always_ff @(posedge c_clk)
  begin
    case (state)
      WR_IDLE:
        if (start)
        begin
          id_q  <= msg_id;
          pay_q <= msg_data;
        end
      WR_HEADER:
        csum <= '0;
      // sum of payload words mod 2^16
      WR_PAYLOAD:
      begin
        csum  <= csum + pay_q[PAYLOAD_W-1 -: DATA_W];
        pay_q <= pay_q << DATA_W;
      end
      default:
        ;
    endcase
  end

  // word mux, one word per active state cycle
  always_comb
  begin
    wr_en   = 1'b0;
    wr_word = {WT_IDLE, {DATA_W{1'b0}}};
    case (state)
      WR_HEADER:
      begin
        wr_en   = 1'b1;
        wr_word = {WT_SOP, {(DATA_W - ID_W){1'b0}}, id_q};
      end
      WR_PAYLOAD:
      begin
        wr_en   = 1'b1;
        wr_word = {WT_DATA, pay_q[PAYLOAD_W-1 -: DATA_W]};
      end
      WR_TRAILER:
      begin
        wr_en   = 1'b1;
        wr_word = {WT_EOP, csum};
      end
      default:
        ;
    endcase
  end

  assign msg_ack = (state == WR_ACK_WAIT);

endmodule

/* hw/epath_frame_reader.sv */
// frame reader for the e-path buffer
// word pop, framing and checksum check, four-phase message offer

`timescale 1ns/10ps

module epath_frame_reader (
  input  logic                            c_clk,
  input  logic                            c_rst,
  input  logic                            rd_enable,
  input  logic [epath_pkg::WORD_W-1:0]    rd_word,
  input  logic                            empty,
  input  logic                            out_ack,
  output logic                            rd_en,
  output logic                            out_req,
  output logic [epath_pkg::ID_W-1:0]      out_id,
  output logic [epath_pkg::PAYLOAD_W-1:0] out_data,
  output logic                            frame_ok,
  output logic                            frame_bad
);
  import epath_pkg::*;

  rd_state_e                      state;
  // read issued last cycle, word valid now
  logic                           rd_pend;
  // payload words taken so far
  logic [$clog2(PAY_WORDS+1)-1:0] idx;
  logic [DATA_W-1:0]              csum;
  logic [DATA_W-1:0]              rx_csum;

  // word decode
  word_type_e                     w_type;
  logic [DATA_W-1:0]              w_data;
  logic                           collecting;
  logic                           start_frame;
  logic                           take_data;
  logic                           take_eop;
  logic                           bad_word;

  assign w_type = word_type_e'(rd_word[WORD_W-1 -: TYPE_W]);
  assign w_data = rd_word[DATA_W-1:0];

  // one read in flight at a time, none while a message is held
  assign collecting = (state == RD_HUNT) || (state == RD_COLLECT);
  assign rd_en      = rd_enable && !empty && !rd_pend && collecting;

  // --------------------
  // word classification
  // --------------------
  // sop restarts collection in hunt or mid-frame
  assign start_frame = rd_pend && collecting && (w_type == WT_SOP);
  assign take_data   = rd_pend && (state == RD_COLLECT) && (w_type == WT_DATA) &&
                       (idx < PAY_WORDS);
  assign take_eop    = rd_pend && (state == RD_COLLECT) && (w_type == WT_EOP) &&
                       (idx == PAY_WORDS);
  // anything else mid-frame is a framing error, sop included
  assign bad_word    = rd_pend && (state == RD_COLLECT) && !take_data && !take_eop;

  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      state     <= RD_HUNT;
      rd_pend   <= 1'b0;
      idx       <= '0;
      frame_ok  <= 1'b0;
      frame_bad <= 1'b0;
    end
    else
    begin
      rd_pend   <= rd_en;
      frame_ok  <= 1'b0;
      frame_bad <= bad_word;
      if (start_frame)
        idx <= '0;
      else if (take_data)
        idx <= idx + 1'b1;
      case (state)
        // stray non-sop words dropped quietly
        RD_HUNT:
          if (start_frame)
            state <= RD_COLLECT;
        RD_COLLECT:
          if (take_eop)
            state <= RD_CHECK;
          else if (bad_word && !start_frame)
            state <= RD_HUNT;
        RD_CHECK:
          if (csum == rx_csum)
            state <= RD_OFFER;
          else
          begin
            frame_bad <= 1'b1;
            state     <= RD_HUNT;
          end
        // frame counted once the sink takes it
        RD_OFFER:
          if (out_ack)
          begin
            frame_ok <= 1'b1;
            state    <= RD_RELEASE;
          end
        RD_RELEASE:
          if (!out_ack)
            state <= RD_HUNT;
        default:
          state <= RD_HUNT;
      endcase
    end
  end

  // message buffer, msw arrives first
  always_ff @(posedge c_clk)
  begin
    if (start_frame)
    begin
      out_id <= w_data[ID_W-1:0];
      csum   <= '0;
    end
    if (take_data)
    begin
      out_data <= {out_data[PAYLOAD_W-DATA_W-1:0], w_data};
      csum     <= csum + w_data;
    end
    if (take_eop)
      rx_csum <= w_data;
  end

  assign out_req = (state == RD_OFFER);

endmodule

/* hw/epath_regs.sv */
// register block for the e-path buffer
// enables, almost-full threshold, frame and error counters, level

`timescale 1ns/10ps

module epath_regs (
  input  logic                          c_clk,
  input  logic                          c_rst,
  input  logic [epath_pkg::REG_AW-1:0]  reg_addr,
  input  logic [epath_pkg::DATA_W-1:0]  reg_wdata,
  input  logic                          reg_we,
  input  logic                          frame_ok,
  input  logic                          frame_bad,
  input  logic [epath_pkg::FIFO_AW-1:0] level,
  output logic [epath_pkg::DATA_W-1:0]  reg_rdata,
  output logic                          wr_enable,
  output logic                          rd_enable,
  output logic [epath_pkg::FIFO_AW-1:0] afull_thresh
);
  import epath_pkg::*;

  reg_addr_e         addr;
  logic [DATA_W-1:0] frames_cnt;
  logic [DATA_W-1:0] errors_cnt;

  assign addr = reg_addr_e'(reg_addr);

  // --------------------
  // writes and counters
  // --------------------
  always_ff @(posedge c_clk or posedge c_rst)
  begin
    if (c_rst)
    begin
      wr_enable    <= 1'b0;
      rd_enable    <= 1'b0;
      afull_thresh <= AFULL_RESET;
      frames_cnt   <= '0;
      errors_cnt   <= '0;
    end
    else
    begin
      // ctrl bit 0 writer, bit 1 reader
      if (reg_we && (addr == REG_CTRL))
      begin
        wr_enable <= reg_wdata[0];
        rd_enable <= reg_wdata[1];
      end
      if (reg_we && (addr == REG_AFULL))
        afull_thresh <= reg_wdata[FIFO_AW-1:0];
      // counters saturate at all ones
      if (frame_ok && (frames_cnt != '1))
        frames_cnt <= frames_cnt + 1'b1;
      // any write clears, wins over a pulse
      if (reg_we && (addr == REG_ERRORS))
        errors_cnt <= '0;
      else if (frame_bad && (errors_cnt != '1))
        errors_cnt <= errors_cnt + 1'b1;
    end
  end

  // combinational readback
  always_comb
  begin
    case (addr)
      REG_CTRL:   reg_rdata = {{(DATA_W - 2){1'b0}}, rd_enable, wr_enable};
      REG_AFULL:  reg_rdata = DATA_W'(afull_thresh);
      REG_FRAMES: reg_rdata = frames_cnt;
      REG_ERRORS: reg_rdata = errors_cnt;
      // level is read only
      REG_LEVEL:  reg_rdata = DATA_W'(level);
      default:    reg_rdata = '0;
    endcase
  end

endmodule

/* hw/epath_top.sv */
// e-path message buffer top level
// writer, FIFO, reader and register block

`timescale 1ns/10ps

module epath_top (
  input  logic                            c_clk,
  input  logic                            c_rst,
  // source side
  input  logic                            msg_req,
  input  logic [epath_pkg::ID_W-1:0]      msg_id,
  input  logic [epath_pkg::PAYLOAD_W-1:0] msg_data,
  output logic                            msg_ack,
  // sink side
  output logic                            out_req,
  output logic [epath_pkg::ID_W-1:0]      out_id,
  output logic [epath_pkg::PAYLOAD_W-1:0] out_data,
  input  logic                            out_ack,
  // register port
  input  logic [epath_pkg::REG_AW-1:0]    reg_addr,
  input  logic [epath_pkg::DATA_W-1:0]    reg_wdata,
  input  logic                            reg_we,
  output logic [epath_pkg::DATA_W-1:0]    reg_rdata
);
  import epath_pkg::*;

  // --------------------
  // internal nets
  // --------------------
  logic               wr_enable;
  logic               rd_enable;
  logic [FIFO_AW-1:0] afull_thresh;
  logic               wr_en;
  logic [WORD_W-1:0]  wr_word;
  logic               rd_en;
  logic [WORD_W-1:0]  rd_word;
  logic               empty;
  logic               almost_full;
  logic [FIFO_AW-1:0] level;
  logic               frame_ok;
  logic               frame_bad;

  epath_regs i_regs (
    .c_clk(c_clk), .c_rst(c_rst),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we),
    .frame_ok(frame_ok), .frame_bad(frame_bad), .level(level),
    .reg_rdata(reg_rdata), .wr_enable(wr_enable), .rd_enable(rd_enable),
    .afull_thresh(afull_thresh)
  );

  epath_frame_writer i_writer (
    .c_clk(c_clk), .c_rst(c_rst), .wr_enable(wr_enable),
    .msg_req(msg_req), .msg_id(msg_id), .msg_data(msg_data),
    .almost_full(almost_full),
    .msg_ack(msg_ack), .wr_en(wr_en), .wr_word(wr_word)
  );

  epath_fifo i_fifo (
    .c_clk(c_clk), .c_rst(c_rst),
    .wr_en(wr_en), .wr_word(wr_word), .rd_en(rd_en), .afull_thresh(afull_thresh),
    .rd_word(rd_word), .empty(empty), .almost_full(almost_full), .level(level)
  );

  epath_frame_reader i_reader (
    .c_clk(c_clk), .c_rst(c_rst), .rd_enable(rd_enable),
    .rd_word(rd_word), .empty(empty), .out_ack(out_ack),
    .rd_en(rd_en), .out_req(out_req), .out_id(out_id), .out_data(out_data),
    .frame_ok(frame_ok), .frame_bad(frame_bad)
  );

endmodule

/* bench/epath_assertions.sv */
// concurrent checks bound into the e-path top level
// handshake ordering, output stability, FIFO flags

`timescale 1ns/10ps

module epath_assertions (
  input logic                            c_clk,
  input logic                            c_rst,
  input logic                            msg_req,
  input logic                            msg_ack,
  input logic                            out_req,
  input logic                            out_ack,
  input logic [epath_pkg::ID_W-1:0]      out_id,
  input logic [epath_pkg::PAYLOAD_W-1:0] out_data,
  input logic                            wr_en,
  input logic [epath_pkg::FIFO_AW-1:0]   level,
  input logic [epath_pkg::FIFO_AW-1:0]   afull_thresh
);
  import epath_pkg::*;

  // --------------------
  // four-phase ordering
  // --------------------
  // ack drops only once req is gone
  a_msg_ack_fall: assert property (@(posedge c_clk) disable iff (c_rst)
    $fell(msg_ack) |-> !$past(msg_req))
    else $error("msg_ack fell while msg_req was high");

  // req drops only once the sink acked
  a_out_req_fall: assert property (@(posedge c_clk) disable iff (c_rst)
    $fell(out_req) |-> $past(out_ack))
    else $error("out_req fell without out_ack");

  a_out_stable: assert property (@(posedge c_clk) disable iff (c_rst)
    (out_req && $past(out_req)) |-> ($stable(out_id) && $stable(out_data)))
    else $error("out_id or out_data changed during offer");

  // FIFO flags
  // a frame starts only when the level was below the threshold
  a_afull: assert property (@(posedge c_clk) disable iff (c_rst)
    $rose(wr_en) |-> ($past(level) < $past(afull_thresh)))
    else $error("frame started at or above the almost-full threshold");

  // only a threshold above depth minus a frame may overrun
  a_no_full_write: assert property (@(posedge c_clk) disable iff (c_rst)
    (wr_en && (afull_thresh <= FIFO_AW'(FIFO_DEPTH - FRAME_WORDS)))
      |-> (level != FIFO_AW'(FIFO_DEPTH - 1)))
    else $error("write reached the FIFO while full");

endmodule

/* bench/epath_tb.sv */
// testbench for the e-path message buffer
// stimulus table, source and sink processes, register checks, final report

`timescale 1ns/10ps

module epath_tb;
  import epath_pkg::*;

  localparam int NUM_ROWS       = 12;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 60 + 200;

  logic                 c_clk;
  logic                 c_rst;
  logic                 msg_req;
  logic [ID_W-1:0]      msg_id;
  logic [PAYLOAD_W-1:0] msg_data;
  logic                 msg_ack;
  logic                 out_req;
  logic [ID_W-1:0]      out_id;
  logic [PAYLOAD_W-1:0] out_data;
  logic                 out_ack;
  logic [REG_AW-1:0]    reg_addr;
  logic [DATA_W-1:0]    reg_wdata;
  logic                 reg_we;
  logic [DATA_W-1:0]    reg_rdata;

  // --------------------
  // stimulus table
  // --------------------
  // each row is also the expected message at the sink
  logic [ID_W-1:0]      row_id    [NUM_ROWS];
  logic [PAYLOAD_W-1:0] row_data  [NUM_ROWS];
  int                   row_delay [NUM_ROWS];
  int                   row_phase [NUM_ROWS];

  logic [31:0] rng_state;
  int          src_done;
  int          rx_total;
  int          exp_idx;
  int          n_mismatch;
  int          n_other;
  int          cycles;

  epath_top i_dut (.*);

  bind epath_top epath_assertions i_assertions (.*);

  initial
  begin
    c_clk = 1'b0;
    forever #5 c_clk = ~c_clk;
  end

  // xorshift32 step
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // rows 0-3 pass-through, 4-6 back-pressure, 7-11 overflow
  task automatic build_table();
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      rng_state = next_random(rng_state);
      row_id[i] = rng_state[ID_W-1:0];
      row_data[i][63:32] = rng_state;
      rng_state = next_random(rng_state);
      row_data[i][31:0] = rng_state;
      rng_state = next_random(rng_state);
      row_phase[i] = (i < 4) ? 1 : ((i < 7) ? 2 : 3);
      if (row_phase[i] == 1)
        row_delay[i] = rng_state % 4;
      else if (row_phase[i] == 2)
        row_delay[i] = (i == 4) ? 40 : rng_state % 41;
      else
        row_delay[i] = 0;
    end
  endtask

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge c_clk);
    #1;
    reg_addr  = addr;
    reg_wdata = data;
    reg_we    = 1'b1;
    @(posedge c_clk);
    #1;
    reg_we    = 1'b0;
  endtask

  // readback is combinational, sampled mid-cycle
  task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [DATA_W-1:0] data);
    @(posedge c_clk);
    #1;
    reg_addr = addr;
    #2;
    data = reg_rdata;
  endtask

  task automatic check_reg(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] exp,
                           input string name);
    logic [DATA_W-1:0] v;
    reg_read(addr, v);
    assert (v == exp)
    else
    begin
      n_mismatch++;
      $display("MISMATCH at %0t: %s reads %h, expected %h", $time, name, v, exp);
    end
  endtask

  // four-phase source, one row at a time
  task automatic send_rows(input int first, input int last);
    int lat;
    for (int i = first; i <= last; i++)
    begin
      @(posedge c_clk);
      #1;
      msg_id   = row_id[i];
      msg_data = row_data[i];
      msg_req  = 1'b1;
      lat = 0;
      do
      begin
        @(posedge c_clk);
        #1;
        lat++;
      end
      while (!msg_ack);
      // empty FIFO, no stall on the first frame
      if (i == 0)
        assert (lat == 7)
        else
        begin
          n_mismatch++;
          $display("MISMATCH at %0t: request to ack took %0d cycles, expected 7", $time, lat);
        end
      msg_req = 1'b0;
      do
      begin
        @(posedge c_clk);
        #1;
      end
      while (msg_ack);
      src_done++;
    end
  endtask

  // poll level while waiting for the sink
  task automatic wait_delivered(input int n, input logic check_level);
    logic [DATA_W-1:0] v;
    while (rx_total < n)
    begin
      reg_read(REG_LEVEL, v);
      if (check_level)
        assert (int'(v) <= int'(AFULL_RESET) - 1 + FRAME_WORDS)
        else
        begin
          n_mismatch++;
          $display("MISMATCH at %0t: level %0d above bound", $time, v);
        end
    end
  endtask

  // --------------------
  // sink
  // --------------------
  // overflow rows may be skipped, never reordered or repeated
  initial
  begin : sink_proc
    int   j;
    logic hit;
    forever
    begin
      @(posedge c_clk);
      #1;
      if (out_req)
      begin
        if (exp_idx < NUM_ROWS)
          repeat (row_delay[exp_idx])
          begin
            @(posedge c_clk);
            #1;
          end
        j = exp_idx;
        if (exp_idx < NUM_ROWS && row_phase[exp_idx] == 3)
          while (j < NUM_ROWS && !(row_id[j] == out_id && row_data[j] == out_data))
            j++;
        hit = (j < NUM_ROWS) && (row_id[j] == out_id) && (row_data[j] == out_data);
        assert (hit)
        else
        begin
          n_mismatch++;
          $display("MISMATCH at %0t: got id %h data %h, expected row %0d",
                   $time, out_id, out_data, exp_idx);
        end
        exp_idx = hit ? j + 1 : exp_idx + 1;
        rx_total++;
        out_ack = 1'b1;
        do
        begin
          @(posedge c_clk);
          #1;
        end
        while (out_req);
        out_ack = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge c_clk);
      cycles++;
    end
    n_other++;
    $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    $display("Verification failed");
    $finish;
  end

  // --------------------
  // main sequence
  // --------------------
  initial
  begin : main_seq
    logic [DATA_W-1:0] v;
    c_rst      = 1'b1;
    msg_req    = 1'b0;
    msg_id     = '0;
    msg_data   = '0;
    out_ack    = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_we     = 1'b0;
    rng_state  = 32'h128e;
    src_done   = 0;
    rx_total   = 0;
    exp_idx    = 0;
    n_mismatch = 0;
    n_other    = 0;
    build_table();
    repeat (2) @(posedge c_clk);
    #1;
    c_rst = 1'b0;

    // reset state
    assert (!msg_ack && !out_req)
    else
    begin
      n_mismatch++;
      $display("MISMATCH at %0t: msg_ack or out_req not low after reset", $time);
    end
    check_reg(REG_CTRL, 16'h0, "ctrl");
    check_reg(REG_AFULL, DATA_W'(AFULL_RESET), "afull");
    check_reg(REG_FRAMES, 16'h0, "frames");
    check_reg(REG_ERRORS, 16'h0, "errors");
    check_reg(REG_LEVEL, 16'h0, "level");

    // pass-through
    reg_write(REG_CTRL, 16'h3);
    send_rows(0, 3);
    wait_delivered(4, 1'b0);

    // back-pressure from slow sink
    fork
      send_rows(4, 6);
    join_none
    wait_delivered(7, 1'b1);

    // overflow, reader held off until three frames are in
    reg_write(REG_AFULL, 16'd15);
    reg_write(REG_CTRL, 16'h1);
    fork
      send_rows(7, 11);
    join_none
    while (src_done < 10)
      @(posedge c_clk);
    reg_write(REG_CTRL, 16'h3);
    while (src_done < NUM_ROWS)
      @(posedge c_clk);
    do
      reg_read(REG_LEVEL, v);
    while (v != '0);
    repeat (6) @(posedge c_clk);
    #1;
    while (out_req || out_ack)
    begin
      @(posedge c_clk);
      #1;
    end
    reg_write(REG_AFULL, DATA_W'(AFULL_RESET));
    assert (rx_total >= 9)
    else
    begin
      n_other++;
      $display("only %0d messages delivered, intact overflow frames were lost", rx_total);
    end

    // counters
    reg_read(REG_ERRORS, v);
    assert (v != '0)
    else
    begin
      n_mismatch++;
      $display("MISMATCH at %0t: error counter is 0 after overflow", $time);
    end
    check_reg(REG_FRAMES, DATA_W'(rx_total), "frames");
    reg_write(REG_ERRORS, 16'h1);
    check_reg(REG_ERRORS, 16'h0, "errors after clear");

    $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* project.f */
hw/epath_pkg.sv
hw/epath_fifo.sv
hw/epath_frame_writer.sv
hw/epath_frame_reader.sv
hw/epath_regs.sv
hw/epath_top.sv
bench/epath_assertions.sv
bench/epath_tb.sv
